// ==== Bender.yml ====
package:
  name: pipeline_result_path

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pipeline_pkg.sv
      - dispatch_stage.sv
      - exec_alu.sv
      - exec_mult.sv
      - complete_cdb.sv
      - reorder_buffer.sv
      - pipeline_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pipeline_asserts.sv
      - pipeline_tb.sv

// ==== all.f ====
+incdir+.
pipeline_pkg.sv
dispatch_stage.sv
exec_alu.sv
exec_mult.sv
complete_cdb.sv
reorder_buffer.sv
pipeline_top.sv
pipeline_asserts.sv
pipeline_tb.sv

// ==== complete_cdb.sv ====
/*
  Common data bus arbiter, one result per cycle.
  Fixed priority, multiplier first. The losing unit keeps its result
  and stays busy, so nothing is lost.
*/

`timescale 1ns/1ps
`default_nettype none

module complete_cdb (
    input  pipeline_pkg::cdb_pkt_t alu_result,
    input  pipeline_pkg::cdb_pkt_t mult_result,
    output logic                   alu_grant,
    output logic                   mult_grant,
    output pipeline_pkg::cdb_pkt_t cdb
);

    // multiplier wins any tie
    assign mult_grant = mult_result.valid;
    assign alu_grant  = alu_result.valid && !mult_result.valid;

    // bus follows the winner
    // alu path also covers the idle case since its valid is low then
    always_comb begin
        if (mult_grant) begin
            cdb = mult_result;
        end else begin
            cdb = alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== dispatch_stage.sv ====
/*
  Purely combinational dispatch.
  ready never looks at dispatch_valid, only at buffer space and the
  busy flag of the unit the operation selects.
  Allocation and issue both take effect on the accepting edge.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module dispatch_stage (
    input  logic                      dispatch_valid,
    input  pipeline_pkg::dispatch_op_t dispatch_op,
    input  logic                      rob_full,
    input  logic [`ROB_TAG_BITS-1:0]  alloc_tag,
    input  logic                      alu_busy,
    input  logic                      mult_busy,
    output logic                      dispatch_ready,
    output pipeline_pkg::rob_alloc_t  alloc,
    output pipeline_pkg::issue_pkt_t  alu_issue,
    output pipeline_pkg::issue_pkt_t  mult_issue
);
    import pipeline_pkg::*;

    logic unit_busy;
    logic accept;

    // busy flag of the chosen unit only
    assign unit_busy      = (dispatch_op.fu_sel == FU_MULT) ? mult_busy : alu_busy;
    assign dispatch_ready = !rob_full && !unit_busy;
    assign accept         = dispatch_valid && dispatch_ready;

    // reorder buffer entry at the tail
    assign alloc.valid    = accept;
    assign alloc.dest     = dispatch_op.dest;
    assign alloc.has_dest = dispatch_op.has_dest;

    // same payload to both units, valid steers it
    assign alu_issue  = '{valid: accept && (dispatch_op.fu_sel == FU_ALU),
                          tag: alloc_tag, func: dispatch_op.func,
                          opa: dispatch_op.opa, opb: dispatch_op.opb};
    assign mult_issue = '{valid: accept && (dispatch_op.fu_sel == FU_MULT),
                          tag: alloc_tag, func: dispatch_op.func,
                          opa: dispatch_op.opa, opb: dispatch_op.opb};

endmodule

`default_nettype wire

// ==== exec_alu.sv ====
/*
  Single-cycle ALU with one result register.
  Result is valid the cycle after issue and held until granted.
  A new issue is taken on the same edge that the old result leaves.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module exec_alu (
    input  logic                     clock,
    input  logic                     reset,
    input  pipeline_pkg::issue_pkt_t issue,
    input  logic                     grant,
    output pipeline_pkg::cdb_pkt_t   result,
    output logic                     busy
);
    import pipeline_pkg::*;

    localparam int SHAMT_BITS = $clog2(`XLEN);

    logic [`XLEN-1:0]         alu_value;
    logic                     result_valid;
    logic [`ROB_TAG_BITS-1:0] result_tag;
    logic [`XLEN-1:0]         result_value;

    // shifts use the low bits of operand b only
    always_comb begin
        case (issue.func)
            ALU_ADD: alu_value = issue.opa + issue.opb;
            ALU_SUB: alu_value = issue.opa - issue.opb;
            ALU_AND: alu_value = issue.opa & issue.opb;
            ALU_OR:  alu_value = issue.opa | issue.opb;
            ALU_XOR: alu_value = issue.opa ^ issue.opb;
            ALU_SLL: alu_value = issue.opa << issue.opb[SHAMT_BITS-1:0];
            ALU_SRL: alu_value = issue.opa >> issue.opb[SHAMT_BITS-1:0];
            ALU_SLT: alu_value = {{(`XLEN-1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
            default: alu_value = '0;
        endcase
    end

    // valid held until the bus takes it
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (issue.valid) begin
            result_valid <= 1'b1;
        end else if (grant) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            result_tag   <= issue.tag;
            result_value <= alu_value;
        end
    end

    assign result = '{valid: result_valid, tag: result_tag, value: result_value};
    // free again once the held result is granted
    assign busy   = result_valid && !grant;

endmodule

`default_nettype wire

// ==== exec_mult.sv ====
/*
  Iterative shift-add multiplier, low XLEN bits of the product only.
  Takes XLEN / MULT_CYCLES multiplier bits per cycle, so the result is
  valid MULT_CYCLES cycles after issue and held until granted.
  Unsigned and signed operands give the same low half.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module exec_mult (
    input  logic                     clock,
    input  logic                     reset,
    input  pipeline_pkg::issue_pkt_t issue,
    input  logic                     grant,
    output pipeline_pkg::cdb_pkt_t   result,
    output logic                     busy
);
    localparam int STEP_W    = `XLEN / `MULT_CYCLES;
    localparam int STEP_BITS = $clog2(`MULT_CYCLES);
    localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(`MULT_CYCLES - 1);

    logic                     running;
    logic [STEP_BITS-1:0]     step;
    logic                     result_valid;
    logic [`ROB_TAG_BITS-1:0] run_tag;
    logic [`XLEN-1:0]         mcand;
    logic [`XLEN-1:0]         mplier;
    logic [`XLEN-1:0]         acc;
    logic [`XLEN-1:0]         partial;

    // one slice of the multiplier per cycle
    always_comb begin
        partial = '0;
        for (int i = 0; i < STEP_W; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    ////////////////////////////////////////////////////
    // step control and result hold
    ////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running      <= 1'b0;
            step         <= '0;
            result_valid <= 1'b0;
        end else begin
            if (grant) begin
                result_valid <= 1'b0;
            end
            if (running) begin
                step <= step + 1'b1;
                // last slice lands in acc on this edge
                if (step == STEP_LAST) begin
                    running      <= 1'b0;
                    result_valid <= 1'b1;
                end
            end
            if (issue.valid) begin
                running <= 1'b1;
                step    <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (issue.valid) begin
            mcand   <= issue.opa;
            mplier  <= issue.opb;
            acc     <= '0;
            run_tag <= issue.tag;
        end else if (running) begin
            acc    <= acc + partial;
            mcand  <= mcand << STEP_W;
            mplier <= mplier >> STEP_W;
        end
    end

    assign result = '{valid: result_valid, tag: run_tag, value: acc};
    // busy through compute and hold
    assign busy   = running || (result_valid && !grant);

endmodule

`default_nettype wire

// ==== pipeline_asserts.sv ====
/*
  Concurrent checks bound into the reorder buffer and the multiplier.
  Each bind ties off the ports that do not belong to its target,
  which makes those properties vacuous there.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module pipeline_asserts (
    input logic                     clock,
    input logic                     reset,
    input logic                     alloc_valid,
    input logic                     rob_full,
    input logic [`ROB_TAG_BITS:0]   count,
    input logic                     cdb_valid,
    input logic                     cdb_tag_live,
    input logic                     result_valid,
    input logic                     grant
);

    // fill level bounded, no allocation into a full buffer
    rob_no_overflow: assert property (@(posedge clock) disable iff (reset)
        (count <= `ROB_DEPTH) && !(rob_full && alloc_valid))
        else $error("reorder buffer overflow");

    // result leaves only through a grant
    mult_result_held: assert property (@(posedge clock) disable iff (reset)
        $fell(result_valid) |-> $past(grant))
        else $error("multiplier result dropped before grant");

    // bus tag always names a live entry
    cdb_tag_allocated: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_tag_live)
        else $error("bus tag has no valid entry");

endmodule

bind reorder_buffer pipeline_asserts rob_checks (
    .clock(clock), .reset(reset), .alloc_valid(alloc.valid), .rob_full(rob_full),
    .count(count), .cdb_valid(cdb.valid), .cdb_tag_live(entry_valid[cdb.tag]),
    .result_valid(1'b0), .grant(1'b0)
);

bind exec_mult pipeline_asserts mult_checks (
    .clock(clock), .reset(reset), .alloc_valid(1'b0), .rob_full(1'b0),
    .count('0), .cdb_valid(1'b0), .cdb_tag_live(1'b1),
    .result_valid(result.valid), .grant(grant)
);

`default_nettype wire

// ==== pipeline_cfg.svh ====
/*
  Sizes for the result path of the out-of-order core.
  ROB_TAG_BITS must equal log2 of ROB_DEPTH.
  MULT_CYCLES must divide XLEN and be at least 2.
*/

`ifndef PIPELINE_CFG_SVH
`define PIPELINE_CFG_SVH

// datapath width
`define XLEN         32

// reorder buffer sizing
`define ROB_DEPTH    8
`define ROB_TAG_BITS 3

// architectural register index
`define REG_IDX_BITS 5

// multiplier takes XLEN / MULT_CYCLES multiplier bits per cycle
`define MULT_CYCLES  4

`endif

// ==== pipeline_pkg.sv ====
/*
  Types shared by the dispatch, execute, complete and retire blocks.
  Operations arrive decoded, with operand values already read.
*/

`default_nettype none

`include "pipeline_cfg.svh"

package pipeline_pkg;

    // alu function codes
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_func_t;

    // functional unit select
    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_sel_t;

    // decoded operation offered at the top level
    typedef struct packed {
        alu_func_t                func;
        fu_sel_t                  fu_sel;
        logic [`XLEN-1:0]         opa;
        logic [`XLEN-1:0]         opb;
        logic [`REG_IDX_BITS-1:0] dest;
        logic                     has_dest;
    } dispatch_op_t;

    // operation sent to one functional unit
    typedef struct packed {
        logic                     valid;
        logic [`ROB_TAG_BITS-1:0] tag;
        alu_func_t                func;
        logic [`XLEN-1:0]         opa;
        logic [`XLEN-1:0]         opb;
    } issue_pkt_t;

    // result on the common data bus
    typedef struct packed {
        logic                     valid;
        logic [`ROB_TAG_BITS-1:0] tag;
        logic [`XLEN-1:0]         value;
    } cdb_pkt_t;

    // new reorder buffer entry
    typedef struct packed {
        logic                     valid;
        logic [`REG_IDX_BITS-1:0] dest;
        logic                     has_dest;
    } rob_alloc_t;

    // retired result toward the register file
    typedef struct packed {
        logic                     valid;
        logic                     wr_en;
        logic [`REG_IDX_BITS-1:0] dest;
        logic [`XLEN-1:0]         value;
    } commit_pkt_t;

endpackage

`default_nettype wire

// ==== pipeline_tb.sv ====
/*
  Random testbench for the result path, LCG stimulus from a fixed seed.
  Expected commits come from a model of the ALU and multiplier rules
  and are kept in dispatch order. For commits without a destination
  only valid and the write enable are compared.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module pipeline_tb;
    import pipeline_pkg::*;

    localparam int PERIOD      = 20;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_BURST   = 64;
    localparam int NUM_OPS     = NUM_RANDOM + NUM_BURST + 2;
    localparam int SHAMT_BITS  = $clog2(`XLEN);
    localparam int WATCHDOG_NS = NUM_OPS * (`MULT_CYCLES + `ROB_DEPTH) * PERIOD;

    logic         clock;
    logic         reset;
    logic         dispatch_valid;
    dispatch_op_t dispatch_op;
    logic         dispatch_ready;
    commit_pkt_t  commit;

    logic [31:0]  lcg_state;
    int           errors;
    int           commits;
    // model of the buffer fill level after the last rising edge
    int           occupancy;
    // rising edges since the last accept into each unit
    int           alu_age;
    int           mult_age;
    commit_pkt_t  expected_q [$];

    pipeline_top dut0 (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_ready(dispatch_ready), .commit(commit)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD/2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] actual,
                               input logic [`XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////

    // upper LCG bits, the low ones repeat too soon
    function automatic dispatch_op_t random_op(input fu_sel_t unit);
        dispatch_op_t op;
        logic [31:0]  r;
        r           = next_random();
        op.func     = alu_func_t'(r[31:29]);
        op.fu_sel   = unit;
        op.has_dest = (r[28:27] != 2'b00);
        op.dest     = r[26 -: `REG_IDX_BITS];
        op.opa      = next_random();
        op.opb      = next_random();
        return op;
    endfunction

    function automatic commit_pkt_t model_commit(input dispatch_op_t op);
        commit_pkt_t      want;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a = op.opa;
        b = op.opb;
        if (op.fu_sel == FU_MULT) begin
            // low half of the product
            want.value = a * b;
        end else begin
            case (op.func)
                ALU_ADD: want.value = a + b;
                ALU_SUB: want.value = a - b;
                ALU_AND: want.value = a & b;
                ALU_OR:  want.value = a | b;
                ALU_XOR: want.value = a ^ b;
                ALU_SLL: want.value = a << b[SHAMT_BITS-1:0];
                ALU_SRL: want.value = a >> b[SHAMT_BITS-1:0];
                ALU_SLT: want.value = ($signed(a) < $signed(b)) ? 1 : 0;
                default: want.value = '0;
            endcase
        end
        want.valid = 1'b1;
        want.wr_en = op.has_dest;
        want.dest  = op.dest;
        return want;
    endfunction

    // commit seen at a falling edge retired on the rising edge before
    task automatic observe_commit();
        commit_pkt_t want;
        if (commit.valid) begin
            occupancy--;
            commits++;
            if (expected_q.size() == 0) begin
                $display("ERROR at %0t ns: commit with no operation outstanding", $time);
                errors++;
            end else begin
                want = expected_q.pop_front();
                check_value("commit.wr_en", commit.wr_en, want.wr_en);
                if (want.wr_en) begin
                    check_value("commit.dest", commit.dest, want.dest);
                    check_value("commit.value", commit.value, want.value);
                end
            end
        end
    endtask

    // one clock, then take in what the last rising edge retired
    task automatic advance_cycle();
        @(negedge clock);
        alu_age++;
        mult_age++;
        observe_commit();
    endtask

    // eight outstanding means no more room
    task automatic check_dispatch_ready();
        logic unit_free;
        // multiplier free once its result is on the bus
        // alu result gone two cycles after issue at the latest
        if (dispatch_op.fu_sel == FU_MULT) begin
            unit_free = (mult_age > `MULT_CYCLES);
        end else begin
            unit_free = (alu_age >= 2);
        end
        if (occupancy >= `ROB_DEPTH) begin
            check_value("dispatch_ready", dispatch_ready, 1'b0);
        end else if (unit_free) begin
            check_value("dispatch_ready", dispatch_ready, 1'b1);
        end
    endtask

    // hold the op until ready is seen before a rising edge
    task automatic send_op(input dispatch_op_t op);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            advance_cycle();
            dispatch_valid = 1'b1;
            dispatch_op    = op;
            #(PERIOD/4);
            check_dispatch_ready();
            taken = dispatch_ready;
        end
        expected_q.push_back(model_commit(op));
        occupancy++;
        if (op.fu_sel == FU_MULT) begin
            mult_age = 0;
        end else begin
            alu_age = 0;
        end
    endtask

    task automatic idle_cycle();
        advance_cycle();
        dispatch_valid = 1'b0;
        #(PERIOD/4);
        check_dispatch_ready();
    endtask

    ////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        fu_sel_t     unit;
        lcg_state      = 32'h7816;
        errors         = 0;
        commits        = 0;
        occupancy      = 0;
        alu_age        = `MULT_CYCLES + 1;
        mult_age       = `MULT_CYCLES + 1;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = '0;

        // two rising edges under reset
        repeat (2) begin
            @(negedge clock);
            check_value("commit.valid", commit.valid, 1'b0);
            check_value("dispatch_ready", dispatch_ready, 1'b1);
        end
        reset = 1'b0;
        idle_cycle();
        check_value("commit.valid", commit.valid, 1'b0);
        check_value("dispatch_ready", dispatch_ready, 1'b1);

        // mixed ops with random gaps
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_random();
            repeat (r[31:30]) idle_cycle();
            unit = (r[29:28] == 2'b00) ? FU_MULT : FU_ALU;
            send_op(random_op(unit));
        end

        // alu right behind a multiply still commits second
        send_op(random_op(FU_MULT));
        send_op(random_op(FU_ALU));

        // back to back, faster than retirement
        for (int i = 0; i < NUM_BURST; i++) begin
            unit = (i % 4 == 0) ? FU_MULT : FU_ALU;
            send_op(random_op(unit));
        end

        // drain, then watch for stray commits
        while (expected_q.size() != 0) begin
            idle_cycle();
        end
        repeat (`ROB_DEPTH) idle_cycle();
        check_value("commit count", commits, NUM_OPS);

        $display("checked %0d commits, %0d errors", commits, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
        $display("checked %0d commits, %0d errors", commits, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipeline_top.sv ====
/*
  Result path top level. Dispatch, two units, bus and reorder buffer.
  Operations arrive decoded with operand values. Commits are always
  accepted by the environment.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module pipeline_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       dispatch_valid,
    input  pipeline_pkg::dispatch_op_t dispatch_op,
    output logic                       dispatch_ready,
    output pipeline_pkg::commit_pkt_t  commit
);
    import pipeline_pkg::*;

    // dispatch to buffer
    rob_alloc_t               alloc;
    logic                     rob_full;
    logic [`ROB_TAG_BITS-1:0] alloc_tag;

    // dispatch to units
    issue_pkt_t alu_issue;
    issue_pkt_t mult_issue;
    logic       alu_busy;
    logic       mult_busy;

    // units to bus
    cdb_pkt_t alu_result;
    cdb_pkt_t mult_result;
    logic     alu_grant;
    logic     mult_grant;
    cdb_pkt_t cdb;

    dispatch_stage dispatch0 (
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .rob_full(rob_full), .alloc_tag(alloc_tag),
        .alu_busy(alu_busy), .mult_busy(mult_busy),
        .dispatch_ready(dispatch_ready), .alloc(alloc),
        .alu_issue(alu_issue), .mult_issue(mult_issue)
    );

    exec_alu alu0 (
        .clock(clock), .reset(reset), .issue(alu_issue), .grant(alu_grant),
        .result(alu_result), .busy(alu_busy)
    );

    exec_mult mult0 (
        .clock(clock), .reset(reset), .issue(mult_issue), .grant(mult_grant),
        .result(mult_result), .busy(mult_busy)
    );

    complete_cdb cdb0 (
        .alu_result(alu_result), .mult_result(mult_result),
        .alu_grant(alu_grant), .mult_grant(mult_grant), .cdb(cdb)
    );

    reorder_buffer rob0 (
        .clock(clock), .reset(reset), .alloc(alloc), .cdb(cdb),
        .rob_full(rob_full), .alloc_tag(alloc_tag), .commit(commit)
    );

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
/*
  Circular in-order reorder buffer, ROB_DEPTH entries.
  Tag of an entry is its slot index, handed out from the tail.
  Results are captured from the bus by tag. One entry retires per
  cycle at most, the edge after it is done. commit is registered
  and has no back-pressure.
*/

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module reorder_buffer (
    input  logic                        clock,
    input  logic                        reset,
    input  pipeline_pkg::rob_alloc_t    alloc,
    input  pipeline_pkg::cdb_pkt_t      cdb,
    output logic                        rob_full,
    output logic [`ROB_TAG_BITS-1:0]    alloc_tag,
    output pipeline_pkg::commit_pkt_t   commit
);
    logic [`ROB_TAG_BITS-1:0] head;
    logic [`ROB_TAG_BITS-1:0] tail;
    logic [`ROB_TAG_BITS:0]   count;

    // per entry state
    logic [`ROB_DEPTH-1:0]    entry_valid;
    logic [`ROB_DEPTH-1:0]    entry_done;
    logic [`REG_IDX_BITS-1:0] entry_dest [`ROB_DEPTH];
    logic                     entry_has_dest [`ROB_DEPTH];
    logic [`XLEN-1:0]         entry_value [`ROB_DEPTH];

    logic                     commit_valid;
    logic                     commit_wr_en;
    logic [`REG_IDX_BITS-1:0] commit_dest;
    logic [`XLEN-1:0]         commit_value;

    logic                     retire;
    logic                     cdb_hit;

    assign rob_full  = (count == `ROB_DEPTH);
    assign alloc_tag = tail;
    assign retire    = entry_valid[head] && entry_done[head];
    // ignore a tag with no live entry
    assign cdb_hit   = cdb.valid && entry_valid[cdb.tag];

    ////////////////////////////////////////////////////
    // pointers, count and flags
    ////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            entry_valid  <= '0;
            entry_done   <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc.valid) begin
                entry_valid[tail] <= 1'b1;
                entry_done[tail]  <= 1'b0;
                tail              <= tail + 1'b1;
            end
            if (cdb_hit) begin
                entry_done[cdb.tag] <= 1'b1;
            end
            // head slot frees up here
            if (retire) begin
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            count        <= count + alloc.valid - retire;
            commit_valid <= retire;
        end
    end

    ////////////////////////////////////////////////////
    // entry payload and commit fields
    ////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (alloc.valid) begin
            entry_dest[tail]     <= alloc.dest;
            entry_has_dest[tail] <= alloc.has_dest;
        end
        if (cdb_hit) begin
            entry_value[cdb.tag] <= cdb.value;
        end
        if (retire) begin
            commit_wr_en <= entry_has_dest[head];
            commit_dest  <= entry_dest[head];
            commit_value <= entry_value[head];
        end
    end

    assign commit = '{valid: commit_valid, wr_en: commit_wr_en,
                      dest: commit_dest, value: commit_value};

endmodule

`default_nettype wire
